// File: logic/eth_rx_pkg.sv
package eth_rx_pkg;

   // Station address, most significant byte goes first on the wire
   localparam logic [47:0] MAC_ADDR   = 48'h00_0A_35_01_02_03;
   localparam logic [47:0] BCAST_ADDR = 48'hFFFF_FFFF_FFFF;
   localparam int          DEST_BYTES = 6;

   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;

   // CRC-32 over the frame after the SFD
   localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;
   // Polynomial 0x04C11DB7 bit-reversed for the LSB-first update
   localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;
   // Left in the register (MSB-first view) after data plus a good FCS
   localparam logic [31:0] CRC_RESIDUE   = 32'hC704_DD7B;

   // Frame buffer geometry and byte counter
   localparam int BUF_ADDR_W = 9;
   localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
   localparam int SIZE_W     = 11;

   typedef enum logic [2:0] {
      st_idle,
      st_preamble,
      st_dest,
      st_payload,
      st_done,
      st_drop
   } rx_state_t;

endpackage

// File: logic/mii_nibble_assembler.sv
`timescale 1ns/100ps

module mii_nibble_assembler (
   input  logic       RX_CLK,
   input  logic       rst,
   input  logic [3:0] rx_data,
   input  logic       rx_dv,
   output logic       byte_valid,
   output logic [7:0] byte_data
);

   // High when the next nibble completes a byte
   logic       phase;
   logic [3:0] low_nib;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         phase      <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= rx_dv & phase;
         // Pairing restarts on every gap in rx_dv
         if (!rx_dv) begin
            phase <= 1'b0;
         end else begin
            phase <= ~phase;
         end
      end
   end

   // Low nibble arrives first on MII
   always_ff @(posedge RX_CLK) begin
      if (rx_dv && !phase) begin
         low_nib <= rx_data;
      end
      if (rx_dv && phase) begin
         byte_data <= {rx_data, low_nib};
      end
   end

endmodule

// File: logic/eth_crc32.sv
`timescale 1ns/100ps

module eth_crc32 (
   input  logic       RX_CLK,
   input  logic       rst,
   input  logic       frame_start,
   input  logic       byte_accept,
   input  logic [7:0] byte_data,
   output logic       crc_good
);

   import eth_rx_pkg::*;

   logic [31:0] crc_q;
   logic [31:0] crc_next;
   logic [31:0] crc_rev;

   // One byte per cycle, bits taken LSB first
   always_comb begin
      crc_next = crc_q ^ {24'h0, byte_data};
      for (int i = 0; i < 8; i++) begin
         if (crc_next[0]) begin
            crc_next = (crc_next >> 1) ^ CRC_POLY_REFL;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         crc_q <= CRC_INIT;
      end else if (frame_start) begin
         crc_q <= CRC_INIT;
      end else if (byte_accept) begin
         crc_q <= crc_next;
      end
   end

   // Residue is quoted in MSB-first order, so flip the register
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc_rev[i] = crc_q[31-i];
      end
   end

   assign crc_good = (crc_rev == CRC_RESIDUE);

endmodule

// File: logic/rx_word_packer.sv
`timescale 1ns/100ps

module rx_word_packer (
   input  logic                               RX_CLK,
   input  logic                               rst,
   input  logic                               frame_start,
   input  logic                               byte_accept,
   input  logic [7:0]                         byte_data,
   output logic                               buf_wr,
   output logic [eth_rx_pkg::BUF_ADDR_W-1:0] buf_addr,
   output logic [31:0]                        buf_wdata,
   output logic [eth_rx_pkg::SIZE_W-1:0]     byte_count
);

   import eth_rx_pkg::*;

   logic [SIZE_W-1:0] byte_addr;
   logic [31:0]       word_q;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         byte_addr <= '0;
         buf_wr    <= 1'b0;
      end else begin
         buf_wr <= byte_accept;
         if (frame_start) begin
            byte_addr <= '0;
         end else if (byte_accept) begin
            byte_addr <= byte_addr + 1'b1;
         end
      end
   end

   // Byte k lands in lane k mod 4, lane 0 is the low byte
   // A fresh word starts with its upper lanes zeroed
   always_ff @(posedge RX_CLK) begin
      if (byte_accept) begin
         buf_addr <= byte_addr[SIZE_W-1:2];
         if (byte_addr[1:0] == 2'd0) begin
            word_q <= {24'h0, byte_data};
         end else begin
            word_q[8*byte_addr[1:0] +: 8] <= byte_data;
         end
      end
   end

   // Partial word is rewritten on every byte, so the tail needs no flush
   assign buf_wdata  = word_q;
   assign byte_count = byte_addr;

   a_no_wrap : assert property (@(posedge RX_CLK) disable iff (rst)
      byte_accept |=> byte_count != '0)
      else $error("byte counter wrapped inside a frame");

endmodule

// File: logic/rx_frame_buffer.sv
`timescale 1ns/100ps

module rx_frame_buffer (
   input  logic                               RX_CLK,
   input  logic                               buf_wr,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] buf_addr,
   input  logic [31:0]                        buf_wdata,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]                        rd_data
);

   import eth_rx_pkg::*;

   logic [31:0] mem [BUF_DEPTH];

   // Write port, driven by the packer
   always_ff @(posedge RX_CLK) begin
      if (buf_wr) begin
         mem[buf_addr] <= buf_wdata;
      end
   end

   // Host read, one cycle latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: logic/eth_rx_ctrl.sv
`timescale 1ns/100ps

module eth_rx_ctrl (
   input  logic                           RX_CLK,
   input  logic                           rst,
   input  logic                           rx_dv,
   input  logic                           byte_valid,
   input  logic [7:0]                     byte_data,
   input  logic                           rcv_ack,
   input  logic                           crc_good,
   input  logic [eth_rx_pkg::SIZE_W-1:0] byte_count,
   output logic                           frame_start,
   output logic                           byte_accept,
   output logic                           data_rcvd,
   output logic                           crc_ok,
   output logic [eth_rx_pkg::SIZE_W-1:0] rcv_size
);

   import eth_rx_pkg::*;

   rx_state_t  state;
   logic [2:0] dest_cnt;
   logic       own_match;
   logic       bc_match;
   logic       eof_pend;
   logic [7:0] own_byte;
   logic [7:0] bc_byte;
   logic       own_hit;
   logic       bc_hit;

   // Destination byte expected at this position, MSB first
   assign own_byte = MAC_ADDR[8*(DEST_BYTES-1-dest_cnt) +: 8];
   assign bc_byte  = BCAST_ADDR[8*(DEST_BYTES-1-dest_cnt) +: 8];
   assign own_hit  = own_match && (byte_data == own_byte);
   assign bc_hit   = bc_match && (byte_data == bc_byte);

   assign frame_start = (state == st_preamble) && byte_valid && (byte_data == SFD_BYTE);
   assign byte_accept = byte_valid && ((state == st_dest) || (state == st_payload));

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         state     <= st_idle;
         dest_cnt  <= '0;
         own_match <= 1'b0;
         bc_match  <= 1'b0;
         eof_pend  <= 1'b0;
         data_rcvd <= 1'b0;
         crc_ok    <= 1'b0;
         rcv_size  <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (byte_valid) begin
                  state <= (byte_data == PREAMBLE_BYTE) ? st_preamble : st_drop;
               end
            end
            st_preamble: begin
               if (byte_valid && byte_data == SFD_BYTE) begin
                  state     <= st_dest;
                  dest_cnt  <= '0;
                  own_match <= 1'b1;
                  bc_match  <= 1'b1;
               end else if (!rx_dv) begin
                  state <= st_idle;
               end else if (byte_valid && byte_data != PREAMBLE_BYTE) begin
                  state <= st_drop;
               end
            end
            st_dest: begin
               if (byte_valid) begin
                  own_match <= own_hit;
                  bc_match  <= bc_hit;
                  dest_cnt  <= dest_cnt + 1'b1;
                  // Decide on the last address byte
                  if (dest_cnt == DEST_BYTES - 1) begin
                     state <= (own_hit || bc_hit) ? st_payload : st_drop;
                  end
               end else if (!rx_dv) begin
                  state <= st_idle;
               end
            end
            st_payload: begin
               // One cycle for the final byte to reach the counter and CRC
               if (eof_pend) begin
                  eof_pend  <= 1'b0;
                  data_rcvd <= 1'b1;
                  rcv_size  <= byte_count;
                  crc_ok    <= crc_good;
                  state     <= st_done;
               end else if (!rx_dv) begin
                  eof_pend <= 1'b1;
               end
            end
            st_done: begin
               // A frame in flight at ack time is flushed through drop
               if (rcv_ack) begin
                  data_rcvd <= 1'b0;
                  state     <= rx_dv ? st_drop : st_idle;
               end
            end
            st_drop: begin
               if (!rx_dv) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   a_accept_held : assert property (@(posedge RX_CLK) disable iff (rst)
      data_rcvd |-> !byte_accept)
      else $error("byte_accept high while data_rcvd is held in %s", state.name());

   a_rcvd_dv : assert property (@(posedge RX_CLK) disable iff (rst)
      $rose(data_rcvd) |-> !rx_dv)
      else $error("data_rcvd rose with rx_dv high in %s", state.name());

endmodule

// File: logic/eth_rx_top.sv
`timescale 1ns/100ps

module eth_rx_top (
   input  logic                               RX_CLK,
   input  logic                               rst,
   input  logic [3:0]                         rx_data,
   input  logic                               rx_dv,
   input  logic                               rcv_ack,
   input  logic [eth_rx_pkg::BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]                        rd_data,
   output logic                               data_rcvd,
   output logic [eth_rx_pkg::SIZE_W-1:0]     rcv_size,
   output logic                               crc_ok
);

   import eth_rx_pkg::*;

   logic                  byte_valid;
   logic [7:0]            byte_data;
   logic                  frame_start;
   logic                  byte_accept;
   logic                  crc_good;
   logic [SIZE_W-1:0]     byte_count;
   logic                  buf_wr;
   logic [BUF_ADDR_W-1:0] buf_addr;
   logic [31:0]           buf_wdata;

   mii_nibble_assembler u_nibble (
      .RX_CLK     (RX_CLK),
      .rst        (rst),
      .rx_data    (rx_data),
      .rx_dv      (rx_dv),
      .byte_valid (byte_valid),
      .byte_data  (byte_data)
   );

   eth_rx_ctrl u_ctrl (
      .RX_CLK      (RX_CLK),
      .rst         (rst),
      .rx_dv       (rx_dv),
      .byte_valid  (byte_valid),
      .byte_data   (byte_data),
      .rcv_ack     (rcv_ack),
      .crc_good    (crc_good),
      .byte_count  (byte_count),
      .frame_start (frame_start),
      .byte_accept (byte_accept),
      .data_rcvd   (data_rcvd),
      .crc_ok      (crc_ok),
      .rcv_size    (rcv_size)
   );

   eth_crc32 u_crc (
      .RX_CLK      (RX_CLK),
      .rst         (rst),
      .frame_start (frame_start),
      .byte_accept (byte_accept),
      .byte_data   (byte_data),
      .crc_good    (crc_good)
   );

   rx_word_packer u_packer (
      .RX_CLK      (RX_CLK),
      .rst         (rst),
      .frame_start (frame_start),
      .byte_accept (byte_accept),
      .byte_data   (byte_data),
      .buf_wr      (buf_wr),
      .buf_addr    (buf_addr),
      .buf_wdata   (buf_wdata),
      .byte_count  (byte_count)
   );

   rx_frame_buffer u_buffer (
      .RX_CLK    (RX_CLK),
      .buf_wr    (buf_wr),
      .buf_addr  (buf_addr),
      .buf_wdata (buf_wdata),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

endmodule

// File: tb/tb_eth_rx.sv
`timescale 1ns/100ps

module tb_eth_rx;

   logic        RX_CLK = 1'b0;
   logic        rst = 1'b1;
   logic [3:0]  rx_data = '0;
   logic        rx_dv = 1'b0;
   logic        rcv_ack = 1'b0;
   logic [8:0]  rd_addr = '0;
   logic [31:0] rd_data;
   logic        data_rcvd;
   logic [10:0] rcv_size;
   logic        crc_ok;

   // Flat token list from the stimulus file
   logic [7:0]  stim [0:511];
   int          seed = 32'h1979_c6d4;
   int          cycles = 0;
   int          limit = 1000000;
   int          errors = 0;
   int          passed = 0;
   int          failed = 0;
   // Header offset of the frame still waiting for ack, -1 if none
   int          held_ptr = -1;

   eth_rx_top u_dut (
      .RX_CLK    (RX_CLK),
      .rst       (rst),
      .rx_data   (rx_data),
      .rx_dv     (rx_dv),
      .rcv_ack   (rcv_ack),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .data_rcvd (data_rcvd),
      .rcv_size  (rcv_size),
      .crc_ok    (crc_ok)
   );

   always #5 RX_CLK = ~RX_CLK;

   always @(posedge RX_CLK) begin
      cycles++;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the frame sequence did not complete", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic tick();
      @(posedge RX_CLK);
      #1;
   endtask

   // MII order, low nibble first
   task automatic send_byte(input logic [7:0] b);
      tick();
      rx_dv = 1'b1;
      rx_data = b[3:0];
      tick();
      rx_data = b[7:4];
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // Byte k sits in lane k mod 4 of word k div 4, unused lanes are masked
   task automatic check_buffer(input int ptr);
      int          n;
      logic [31:0] exp_w;
      logic [31:0] mask;
      n = stim[ptr];
      for (int w = 0; w < (n + 3) / 4; w++) begin
         exp_w = '0;
         mask = '0;
         for (int j = 0; j < 4; j++) begin
            if (4 * w + j < n) begin
               exp_w[8*j +: 8] = stim[ptr + 4 + 4 * w + j];
               mask[8*j +: 8] = 8'hFF;
            end
         end
         tick();
         rd_addr = w;
         @(posedge RX_CLK);
         @(negedge RX_CLK);
         check_val($sformatf("rd_data[%0d]", w), rd_data & mask, exp_w);
      end
   endtask

   task automatic report(input string name, input int err_before);
      if (errors == err_before) begin
         passed++;
         $display("%s: passed", name);
      end else begin
         failed++;
         $display("%s: failed with %0d errors", name, errors - err_before);
      end
   endtask

   initial begin
      int   ptr;
      int   n;
      int   frame;
      int   err_before;
      logic got;
      $readmemh("tb/eth_rx_stimulus.txt", stim);
      ptr = 0;
      limit = 200;
      while (stim[ptr] != 8'h00) begin
         limit += 2 * stim[ptr] + 60;
         ptr += 4 + stim[ptr];
      end
      err_before = errors;
      repeat (10) begin
         @(negedge RX_CLK);
         check_val("data_rcvd", data_rcvd, 0);
         check_val("crc_ok", crc_ok, 0);
         check_val("rcv_size", rcv_size, 0);
      end
      tick();
      rst = 1'b0;
      @(negedge RX_CLK);
      check_val("data_rcvd", data_rcvd, 0);
      check_val("crc_ok", crc_ok, 0);
      check_val("rcv_size", rcv_size, 0);
      report("Reset", err_before);
      ptr = 0;
      frame = 0;
      while (stim[ptr] != 8'h00) begin
         n = stim[ptr];
         err_before = errors;
         for (int i = 0; i < 8; i++) begin
            send_byte(i < 7 ? 8'h55 : 8'hD5);
         end
         for (int i = 0; i < n; i++) begin
            send_byte(stim[ptr + 4 + i]);
         end
         tick();
         rx_dv = 1'b0;
         rx_data = '0;
         if (stim[ptr + 1][0]) begin
            got = 1'b0;
            for (int i = 0; i < 3 && !got; i++) begin
               @(negedge RX_CLK);
               got = data_rcvd;
            end
            assert (got) else begin
               $display("data_rcvd did not rise within 3 cycles after frame %0d ended", frame);
               errors++;
            end
            check_val("rcv_size", rcv_size, n);
            check_val("crc_ok", crc_ok, stim[ptr + 2][0]);
            check_buffer(ptr);
         end else begin
            // Dropped frame, or one that arrived while the last is still held
            repeat (20) begin
               @(negedge RX_CLK);
               check_val("data_rcvd", data_rcvd, held_ptr >= 0);
            end
            if (held_ptr >= 0) begin
               check_val("rcv_size", rcv_size, stim[held_ptr]);
               check_val("crc_ok", crc_ok, stim[held_ptr + 2][0]);
               check_buffer(held_ptr);
            end
         end
         if (data_rcvd && stim[ptr + 3][0]) begin
            tick();
            rcv_ack = 1'b1;
            tick();
            rcv_ack = 1'b0;
            @(negedge RX_CLK);
            check_val("data_rcvd", data_rcvd, 0);
            held_ptr = -1;
         end else if (data_rcvd && held_ptr < 0) begin
            held_ptr = ptr;
         end
         report($sformatf("Frame %0d, %0d bytes", frame, n), err_before);
         repeat (12 + ($random(seed) & 7)) tick();
         ptr += 4 + n;
         frame++;
      end
      $display("Tests passed: %0d, failed: %0d", passed, failed);
      if (errors == 0 && failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: verilog.f
logic/eth_rx_pkg.sv
logic/mii_nibble_assembler.sv
logic/eth_crc32.sv
logic/rx_word_packer.sv
logic/rx_frame_buffer.sv
logic/eth_rx_ctrl.sv
logic/eth_rx_top.sv
tb/tb_eth_rx.sv

// File: tb/eth_rx_stimulus.txt
// Header per frame: byte count, accept, crc_ok, ack after the frame (hex)
// Next line: frame bytes after the SFD with the FCS last, a count of 00 ends the list
0C 1 1 1
00 0A 35 01 02 03 60 81 4A 91 88 FF
0A 1 1 1
FF FF FF FF FF FF 00 ED D9 41
0A 0 0 1
00 0A 35 01 02 04 11 22 33 44
0C 1 1 1
00 0A 35 01 02 03 60 81 4A 91 88 FF
0C 1 0 1
00 0A 35 01 02 03 60 81 4A 91 88 FE
0A 1 1 0
FF FF FF FF FF FF 00 ED D9 41
0C 0 0 1
00 0A 35 01 02 03 60 81 4A 91 88 FF
0C 1 1 1
00 0A 35 01 02 03 60 81 4A 91 88 FF
00
